// File: project.f
verilog/fabric_pkg.sv
verilog/tim.sv
verilog/tim_router.sv
verilog/per_arbiter.sv
verilog/per_decoder.sv
verilog/ram.sv
verilog/clint.sv
verilog/mem_fabric.sv
sim/tb_mem_fabric.sv

// File: Bender.yml
package:
  name: mem_fabric

sources:
  - verilog/fabric_pkg.sv
  - verilog/tim.sv
  - verilog/tim_router.sv
  - verilog/per_arbiter.sv
  - verilog/per_decoder.sv
  - verilog/ram.sv
  - verilog/clint.sv
  - verilog/mem_fabric.sv
  - target: simulation
    files:
      - sim/tb_mem_fabric.sv

// File: sim/tb_mem_fabric.sv
`default_nettype none

module tb_mem_fabric;

  import fabric_pkg::*;

  logic        clock;
  logic        reset;
  mem_in_type  ins [4];   // imem0, imem1, dmem0, dmem1
  mem_out_type outs [4];
  logic        msip;
  logic        mtip;

  logic [31:0] itim_sh [tim_words];
  logic [31:0] dtim_sh [tim_words];
  logic [31:0] ram_sh [ram_words];
  logic        msip_sh;
  logic [31:0] mtimecmp_sh;

  logic        pend [4];
  logic        pend_tim [4];
  logic        pend_skip [4];  // value not predictable, only captured
  logic [31:0] pend_exp [4];
  int          pend_cycle [4];
  logic [31:0] last_rdata [4];
  int          cycle;
  logic [31:0] rng;

  mem_fabric mem_fabric_inst (
    .clock    (clock),
    .reset    (reset),
    .imem0_in (ins[0]),
    .imem1_in (ins[1]),
    .dmem0_in (ins[2]),
    .dmem1_in (ins[3]),
    .imem0_out(outs[0]),
    .imem1_out(outs[1]),
    .dmem0_out(outs[2]),
    .dmem1_out(outs[3]),
    .msip     (msip),
    .mtip     (mtip)
  );

  always #2 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  // ####################
  // reference model

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic string req_name(input int r);
    case (r)
      0: return "imem0_out";
      1: return "imem1_out";
      2: return "dmem0_out";
      default: return "dmem1_out";
    endcase
  endfunction

  // 0 itim, 1 dtim, 2 ram, 3 clint, 4 unmapped
  function automatic int region_of(input logic [31:0] addr);
    if ((addr & ~itim_mask_addr) == itim_base_addr) return 0;
    if ((addr & ~dtim_mask_addr) == dtim_base_addr) return 1;
    if ((addr & ~ram_mask_addr) == ram_base_addr) return 2;
    if ((addr & ~clint_mask_addr) == clint_base_addr) return 3;
    return 4;
  endfunction

  function automatic logic [31:0] expect_read(input logic [31:0] addr);
    case (region_of(addr))
      0: return itim_sh[addr[11:2]];
      1: return dtim_sh[addr[11:2]];
      2: return ram_sh[addr[9:2]];
      3: begin
        if (addr[3:0] == clint_msip_off[3:0]) return {31'h0, msip_sh};
        if (addr[3:0] == clint_mtimecmp_off[3:0]) return mtimecmp_sh;
        return 32'h0;
      end
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] wstrb);
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) old[8*i +: 8] = wdata[8*i +: 8];
    end
    return old;
  endfunction

  task automatic apply_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
    case (region_of(addr))
      0: itim_sh[addr[11:2]] = merge_bytes(itim_sh[addr[11:2]], wdata, wstrb);
      1: dtim_sh[addr[11:2]] = merge_bytes(dtim_sh[addr[11:2]], wdata, wstrb);
      2: ram_sh[addr[9:2]] = merge_bytes(ram_sh[addr[9:2]], wdata, wstrb);
      3: begin
        if (addr[3:0] == clint_msip_off[3:0] && wstrb[0]) msip_sh = wdata[0];
        if (addr[3:0] == clint_mtimecmp_off[3:0]) begin
          mtimecmp_sh = merge_bytes(mtimecmp_sh, wdata, wstrb);
        end
      end
      default: ;  // unmapped writes are dropped
    endcase
  endtask

  // ####################
  // checks

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_mem_out(input string name, input mem_out_type exp,
                               input mem_out_type act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // one watcher per requester, sampled mid-cycle
  for (genvar g = 0; g < 4; g++) begin : watch
    always @(negedge clock) begin
      if (reset && outs[g].mem_ready === 1'b1) begin
        if (!pend[g]) begin
          $display("%s gave mem_ready with no request outstanding", req_name(g));
          abort_run();
        end else if (pend_tim[g] && cycle - pend_cycle[g] != 1) begin
          $display("%s answered a TIM access after %0d cycles instead of 1",
                   req_name(g), cycle - pend_cycle[g]);
          abort_run();
        end else begin
          if (pend_skip[g]) begin
            last_rdata[g] = outs[g].mem_rdata;
          end else begin
            check_mem_out(req_name(g), mem_out_type'{mem_ready: 1'b1, mem_rdata: pend_exp[g]},
                          outs[g]);
          end
          pend[g] = 1'b0;
        end
      end
    end
  end

  // ####################
  // stimulus

  task automatic send(input int r, input logic [31:0] addr, input logic [31:0] wdata,
                      input logic [3:0] wstrb, input logic skip = 1'b0);
    ins[r] = '{mem_valid: 1'b1, mem_instr: (r < 2), mem_addr: addr, mem_wdata: wdata,
               mem_wstrb: wstrb};
    pend_exp[r]   = (wstrb == 4'b0) ? expect_read(addr) : 32'h0;
    pend_tim[r]   = region_of(addr) < 2;
    pend_skip[r]  = skip;
    pend_cycle[r] = cycle;
    pend[r]       = 1'b1;
    if (wstrb != 4'b0) apply_write(addr, wdata, wstrb);
  endtask

  task automatic step();
    @(posedge clock);
    #1;
    for (int r = 0; r < 4; r++) begin
      ins[r].mem_valid = 1'b0;  // strobes last one cycle
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((pend[0] || pend[1] || pend[2] || pend[3]) && n < 40) begin
      step();
      n++;
    end
    if (pend[0] || pend[1] || pend[2] || pend[3]) begin
      for (int r = 0; r < 4; r++) begin
        if (pend[r]) $display("response never arrived on %s", req_name(r));
      end
      abort_run();
    end
  endtask

  initial begin
    int          n;
    int          r;
    int          sel;
    logic [31:0] v;
    logic [31:0] addr;
    logic [3:0]  word;
    logic [3:0]  strb;
    clock       = 1'b0;
    reset       = 1'b0;
    cycle       = 0;
    rng         = 32'h98fede38;
    msip_sh     = 1'b0;
    mtimecmp_sh = 32'hFFFF_FFFF;
    for (int i = 0; i < 4; i++) begin
      ins[i]  = init_mem_in;
      pend[i] = 1'b0;
    end
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b1;
    check_bit("msip", 1'b0, msip);
    check_bit("mtip", 1'b0, mtip);

    // TIM fill through dmem0, read back on every requester
    for (int i = 0; i < 16; i++) begin
      send(2, itim_base_addr + 4 * i, rand32(), 4'hF);
      wait_idle();
      send(2, dtim_base_addr + 4 * i, rand32(), 4'hF);
      wait_idle();
    end
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 4; k++) begin
        send(k, itim_base_addr + 4 * i, 32'h0, 4'h0);
        wait_idle();
        send(k, dtim_base_addr + 4 * i, 32'h0, 4'h0);
        wait_idle();
      end
    end

    // both lanes on both TIMs in one cycle
    for (int i = 0; i < 8; i++) begin
      send(0, itim_base_addr + 4 * i, 32'h0, 4'h0);
      send(2, dtim_base_addr + 4 * i, rand32(), (i % 2) ? 4'hF : 4'h0);
      send(1, dtim_base_addr + 4 * (15 - i), 32'h0, 4'h0);  // fetch from dtim
      send(3, itim_base_addr + 4 * (15 - i), rand32(), 4'hF);
      wait_idle();
    end

    // contended RAM writes, byte strobes, then reads
    for (int k = 0; k < 4; k++) begin
      for (int q = 0; q < 4; q++) begin
        send(q, ram_base_addr + 4 * (4 * k + q), rand32(), 4'hF);
      end
      wait_idle();
    end
    for (int q = 0; q < 4; q++) begin
      send(q, ram_base_addr + 4 * q, rand32(), 4'(q + 1) ^ 4'b1000);
    end
    wait_idle();
    for (int k = 0; k < 4; k++) begin
      for (int q = 0; q < 4; q++) begin
        send(q, ram_base_addr + 4 * (4 * k + (3 - q)), 32'h0, 4'h0);
      end
      wait_idle();
    end

    // unmapped
    send(3, 32'h4000_0000, 32'h0, 4'h0);
    wait_idle();
    send(3, 32'h0000_2000, rand32(), 4'hF);
    wait_idle();
    send(3, 32'h4000_0100, 32'h0, 4'h0);
    wait_idle();

    // ####################
    // CLINT
    send(2, clint_base_addr + clint_msip_off, 32'h1, 4'h1);
    wait_idle();
    check_bit("msip", 1'b1, msip);
    send(2, clint_base_addr + clint_msip_off, 32'h0, 4'h0);
    wait_idle();
    send(3, clint_base_addr + clint_mtime_off, 32'h0, 4'h0, 1'b1);
    wait_idle();
    send(3, clint_base_addr + clint_mtimecmp_off, last_rdata[3] + 32'd8, 4'hF);
    wait_idle();
    check_bit("mtip", 1'b0, mtip);
    n = 0;
    while (mtip !== 1'b1 && n < 100) begin
      step();
      n++;
    end
    if (mtip !== 1'b1) begin
      $display("mtip never rose after mtimecmp was set");
      abort_run();
    end
    send(3, clint_base_addr + clint_mtimecmp_off, 32'hFFFF_FFFF, 4'hF);
    wait_idle();
    check_bit("mtip", 1'b0, mtip);
    send(1, clint_base_addr + clint_mtimecmp_off, 32'h0, 4'h0);
    wait_idle();

    // random traffic over every region
    for (int i = 0; i < 300; i++) begin
      v    = rand32();
      r    = v[1:0];
      word = v[11:8];
      sel  = v[6:4] % 5;
      case (sel)
        0: addr = itim_base_addr + {word, 2'b00};
        1: addr = dtim_base_addr + {word, 2'b00};
        2: addr = ram_base_addr + {word, 2'b00};
        3: addr = clint_base_addr + {word[0], 2'b00};  // msip or mtimecmp
        default: addr = 32'h4000_0000 + {word, 2'b00};
      endcase
      strb = (r >= 2 && sel < 3) ? v[15:12] : 4'h0;
      send(r, addr, rand32(), strb);
      wait_idle();
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/mem_fabric.sv
`default_nettype none

module mem_fabric (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  imem0_in,
  input  fabric_pkg::mem_in_type  imem1_in,
  input  fabric_pkg::mem_in_type  dmem0_in,
  input  fabric_pkg::mem_in_type  dmem1_in,
  output fabric_pkg::mem_out_type imem0_out,
  output fabric_pkg::mem_out_type imem1_out,
  output fabric_pkg::mem_out_type dmem0_out,
  output fabric_pkg::mem_out_type dmem1_out,
  output logic                    msip,
  output logic                    mtip
);

  import fabric_pkg::*;

  // ####################
  // TIM and peripheral paths

  mem_in_type  itim0_in, itim1_in, dtim0_in, dtim1_in;
  mem_out_type itim0_out, itim1_out, dtim0_out, dtim1_out;
  mem_in_type  iper0_in, iper1_in, dper0_in, dper1_in;
  mem_out_type iper0_out, iper1_out, dper0_out, dper1_out;

  // ####################
  // peripheral bus

  mem_in_type  per_in, ram_in, clint_in;
  mem_out_type per_out, ram_out, clint_out;

  tim_router tim_router_inst (.*);

  tim itim_inst (
    .clock   (clock),
    .reset   (reset),
    .tim0_in (itim0_in),
    .tim1_in (itim1_in),
    .tim0_out(itim0_out),
    .tim1_out(itim1_out)
  );

  tim dtim_inst (
    .clock   (clock),
    .reset   (reset),
    .tim0_in (dtim0_in),
    .tim1_in (dtim1_in),
    .tim0_out(dtim0_out),
    .tim1_out(dtim1_out)
  );

  per_arbiter per_arbiter_inst (.*);

  per_decoder per_decoder_inst (.*);

  ram ram_inst (.*);

  clint clint_inst (.*);

endmodule

`default_nettype wire

// File: verilog/clint.sv
`default_nettype none

module clint (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  clint_in,
  output fabric_pkg::mem_out_type clint_out,
  output logic                    msip,
  output logic                    mtip
);

  import fabric_pkg::*;

  logic [$clog2(clint_divider)-1:0] div_count;
  logic [31:0] mtime;
  logic [31:0] mtimecmp;
  logic msip_reg;
  logic ready;
  logic [31:0] rdata;
  logic wr;
  logic rd;

  assign wr = clint_in.mem_valid && |clint_in.mem_wstrb;
  assign rd = clint_in.mem_valid && clint_in.mem_wstrb == 4'b0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      div_count <= '0;
      mtime     <= 32'h0;
      mtimecmp  <= '1;  // no timer interrupt out of reset
      msip_reg  <= 1'b0;
      ready     <= 1'b0;
    end else begin
      ready <= clint_in.mem_valid;
      if (div_count == $bits(div_count)'(clint_divider - 1)) begin
        div_count <= '0;
        mtime     <= mtime + 32'd1;
      end else begin
        div_count <= div_count + 1'b1;
      end
      if (wr && clint_in.mem_addr == clint_msip_off && clint_in.mem_wstrb[0]) begin
        msip_reg <= clint_in.mem_wdata[0];
      end
      for (int i = 0; i < 4; i++) begin
        if (wr && clint_in.mem_addr == clint_mtimecmp_off && clint_in.mem_wstrb[i]) begin
          mtimecmp[8*i +: 8] <= clint_in.mem_wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    rdata <= 32'h0;
    if (rd) begin
      case (clint_in.mem_addr)
        clint_msip_off:     rdata <= {31'h0, msip_reg};
        clint_mtimecmp_off: rdata <= mtimecmp;
        clint_mtime_off:    rdata <= mtime;  // read only
        default:            rdata <= 32'h0;
      endcase
    end
  end

  assign clint_out = '{mem_ready: ready, mem_rdata: rdata};
  assign msip = msip_reg;
  assign mtip = mtime >= mtimecmp;

endmodule

`default_nettype wire

// File: verilog/ram.sv
`default_nettype none

module ram (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  ram_in,
  output fabric_pkg::mem_out_type ram_out
);

  import fabric_pkg::*;

  logic [31:0] mem [ram_words];
  logic [$clog2(ram_words)-1:0] addr;
  logic ready;
  logic [31:0] rdata;

  assign addr = ram_in.mem_addr[$clog2(ram_words)+1:2];

  always_ff @(posedge clock) begin
    for (int i = 0; i < 4; i++) begin
      if (ram_in.mem_valid && ram_in.mem_wstrb[i]) begin
        mem[addr][8*i +: 8] <= ram_in.mem_wdata[8*i +: 8];
      end
    end
    rdata <= (ram_in.mem_valid && ram_in.mem_wstrb == 4'b0) ? mem[addr] : 32'h0;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= ram_in.mem_valid;
    end
  end

  assign ram_out = '{mem_ready: ready, mem_rdata: rdata};

endmodule

`default_nettype wire

// File: verilog/per_decoder.sv
`default_nettype none

module per_decoder (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  per_in,
  output fabric_pkg::mem_out_type per_out,
  output fabric_pkg::mem_in_type  ram_in,
  output fabric_pkg::mem_in_type  clint_in,
  input  fabric_pkg::mem_out_type ram_out,
  input  fabric_pkg::mem_out_type clint_out
);

  import fabric_pkg::*;

  logic ram_hit;
  logic clint_hit;
  logic miss_ready;  // unmapped answer, one cycle late like the targets

  assign ram_hit   = per_in.mem_valid && addr_hit(per_in.mem_addr, ram_base_addr, ram_mask_addr);
  assign clint_hit = per_in.mem_valid
                  && addr_hit(per_in.mem_addr, clint_base_addr, clint_mask_addr);

  always_comb begin
    ram_in   = init_mem_in;
    clint_in = init_mem_in;
    if (ram_hit) begin
      ram_in = per_in;
      ram_in.mem_addr = per_in.mem_addr - ram_base_addr;
    end
    if (clint_hit) begin
      clint_in = per_in;
      clint_in.mem_addr = per_in.mem_addr - clint_base_addr;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      miss_ready <= 1'b0;
    end else begin
      miss_ready <= per_in.mem_valid && !ram_hit && !clint_hit;
    end
  end

  always_comb begin
    per_out = init_mem_out;
    if (ram_out.mem_ready) begin
      per_out = ram_out;
    end else if (clint_out.mem_ready) begin
      per_out = clint_out;
    end else if (miss_ready) begin
      per_out = '{mem_ready: 1'b1, mem_rdata: 32'h0};
    end
  end

endmodule

`default_nettype wire

// File: verilog/per_arbiter.sv
`default_nettype none

module per_arbiter (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  iper0_in,
  input  fabric_pkg::mem_in_type  iper1_in,
  input  fabric_pkg::mem_in_type  dper0_in,
  input  fabric_pkg::mem_in_type  dper1_in,
  output fabric_pkg::mem_out_type iper0_out,
  output fabric_pkg::mem_out_type iper1_out,
  output fabric_pkg::mem_out_type dper0_out,
  output fabric_pkg::mem_out_type dper1_out,
  output fabric_pkg::mem_in_type  per_in,
  input  fabric_pkg::mem_out_type per_out
);

  import fabric_pkg::*;

  mem_in_type req [4];   // index is the priority, 0 highest
  mem_in_type slot [4];
  mem_in_type issue_req;
  logic [3:0] strobe;
  logic [3:0] pend;
  logic [3:0] grant_mask;
  logic [1:0] grant;
  logic [1:0] owner;
  logic grant_ok;
  logic busy;         // request on the bus, response not yet back
  logic issue_valid;

  assign req[0] = iper0_in;
  assign req[1] = iper1_in;
  assign req[2] = dper0_in;
  assign req[3] = dper1_in;

  always_comb begin
    strobe = '0;
    grant = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      strobe[i] = req[i].mem_valid;
      if (pend[i]) begin
        grant = 2'(i);
      end
    end
  end

  // the response cycle already frees the bus
  assign grant_ok   = |pend && (!busy || per_out.mem_ready);
  assign grant_mask = grant_ok ? (4'b0001 << grant) : 4'b0000;

  always_ff @(posedge clock) begin
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        slot[i] <= req[i];
      end
    end
    if (grant_ok) begin
      issue_req <= slot[grant];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pend        <= 4'b0;
      busy        <= 1'b0;
      owner       <= 2'd0;
      issue_valid <= 1'b0;
    end else begin
      pend        <= (pend & ~grant_mask) | strobe;
      issue_valid <= grant_ok;
      if (grant_ok) begin
        busy  <= 1'b1;
        owner <= grant;
      end else if (per_out.mem_ready) begin
        busy <= 1'b0;
      end
    end
  end

  always_comb begin
    per_in = issue_req;
    per_in.mem_valid = issue_valid;
  end

  assign iper0_out = (per_out.mem_ready && owner == 2'd0) ? per_out : init_mem_out;
  assign iper1_out = (per_out.mem_ready && owner == 2'd1) ? per_out : init_mem_out;
  assign dper0_out = (per_out.mem_ready && owner == 2'd2) ? per_out : init_mem_out;
  assign dper1_out = (per_out.mem_ready && owner == 2'd3) ? per_out : init_mem_out;

  slot_overrun: assert property (@(posedge clock) disable iff (!reset)
    (strobe & pend) == 4'b0)
    else $error("per_arbiter: new request into full slot %b", strobe & pend);
  single_outstanding: assert property (@(posedge clock) disable iff (!reset)
    per_in.mem_valid |=> (!per_in.mem_valid until_with per_out.mem_ready))
    else $error("per_arbiter: issue before the previous response");

endmodule

`default_nettype wire

// File: verilog/tim_router.sv
`default_nettype none

module tim_router (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  imem0_in,
  input  fabric_pkg::mem_in_type  imem1_in,
  input  fabric_pkg::mem_in_type  dmem0_in,
  input  fabric_pkg::mem_in_type  dmem1_in,
  output fabric_pkg::mem_out_type imem0_out,
  output fabric_pkg::mem_out_type imem1_out,
  output fabric_pkg::mem_out_type dmem0_out,
  output fabric_pkg::mem_out_type dmem1_out,
  output fabric_pkg::mem_in_type  itim0_in,
  output fabric_pkg::mem_in_type  itim1_in,
  output fabric_pkg::mem_in_type  dtim0_in,
  output fabric_pkg::mem_in_type  dtim1_in,
  input  fabric_pkg::mem_out_type itim0_out,
  input  fabric_pkg::mem_out_type itim1_out,
  input  fabric_pkg::mem_out_type dtim0_out,
  input  fabric_pkg::mem_out_type dtim1_out,
  output fabric_pkg::mem_in_type  iper0_in,
  output fabric_pkg::mem_in_type  iper1_in,
  output fabric_pkg::mem_in_type  dper0_in,
  output fabric_pkg::mem_in_type  dper1_in,
  input  fabric_pkg::mem_out_type iper0_out,
  input  fabric_pkg::mem_out_type iper1_out,
  input  fabric_pkg::mem_out_type dper0_out,
  input  fabric_pkg::mem_out_type dper1_out
);

  import fabric_pkg::*;

  logic itim0_dsel;  // set when the data requester owns the port
  logic itim1_dsel;
  logic dtim0_dsel;
  logic dtim1_dsel;

  function automatic logic claims(input mem_in_type req, input logic [31:0] base,
                                  input logic [31:0] mask);
    return req.mem_valid && addr_hit(req.mem_addr, base, mask);
  endfunction

  // instruction side has priority on a shared TIM port
  function automatic mem_in_type pick(input mem_in_type imem, input mem_in_type dmem,
                                      input logic [31:0] base, input logic [31:0] mask);
    mem_in_type req;
    req = init_mem_in;
    if (claims(imem, base, mask)) begin
      req = imem;
      req.mem_addr = imem.mem_addr - base;
    end else if (claims(dmem, base, mask)) begin
      req = dmem;
      req.mem_addr = dmem.mem_addr - base;
    end
    return req;
  endfunction

  function automatic mem_in_type to_per(input mem_in_type req);
    if (!req.mem_valid || claims(req, itim_base_addr, itim_mask_addr)
        || claims(req, dtim_base_addr, dtim_mask_addr)) begin
      return init_mem_in;
    end
    return req;
  endfunction

  function automatic mem_out_type merge(input mem_out_type a, input logic a_en,
                                        input mem_out_type b, input logic b_en,
                                        input mem_out_type c);
    if (a_en && a.mem_ready) return a;
    if (b_en && b.mem_ready) return b;
    if (c.mem_ready) return c;
    return init_mem_out;
  endfunction

  function automatic logic conflict(input mem_in_type imem, input mem_in_type dmem);
    return (claims(imem, itim_base_addr, itim_mask_addr)
            && claims(dmem, itim_base_addr, itim_mask_addr))
        || (claims(imem, dtim_base_addr, dtim_mask_addr)
            && claims(dmem, dtim_base_addr, dtim_mask_addr));
  endfunction

  assign itim0_in = pick(imem0_in, dmem0_in, itim_base_addr, itim_mask_addr);
  assign itim1_in = pick(imem1_in, dmem1_in, itim_base_addr, itim_mask_addr);
  assign dtim0_in = pick(imem0_in, dmem0_in, dtim_base_addr, dtim_mask_addr);
  assign dtim1_in = pick(imem1_in, dmem1_in, dtim_base_addr, dtim_mask_addr);

  assign iper0_in = to_per(imem0_in);
  assign iper1_in = to_per(imem1_in);
  assign dper0_in = to_per(dmem0_in);
  assign dper1_in = to_per(dmem1_in);

  always_ff @(posedge clock) begin
    if (!reset) begin
      itim0_dsel <= 1'b0;
      itim1_dsel <= 1'b0;
      dtim0_dsel <= 1'b0;
      dtim1_dsel <= 1'b0;
    end else begin
      itim0_dsel <= !claims(imem0_in, itim_base_addr, itim_mask_addr);
      itim1_dsel <= !claims(imem1_in, itim_base_addr, itim_mask_addr);
      dtim0_dsel <= !claims(imem0_in, dtim_base_addr, dtim_mask_addr);
      dtim1_dsel <= !claims(imem1_in, dtim_base_addr, dtim_mask_addr);
    end
  end

  assign imem0_out = merge(itim0_out, !itim0_dsel, dtim0_out, !dtim0_dsel, iper0_out);
  assign dmem0_out = merge(itim0_out, itim0_dsel, dtim0_out, dtim0_dsel, dper0_out);
  assign imem1_out = merge(itim1_out, !itim1_dsel, dtim1_out, !dtim1_dsel, iper1_out);
  assign dmem1_out = merge(itim1_out, itim1_dsel, dtim1_out, dtim1_dsel, dper1_out);

  // a losing dmem request would never get its mem_ready
  lane0_tim_conflict: assert property (@(posedge clock) disable iff (!reset)
    !conflict(imem0_in, dmem0_in))
    else $error("tim_router: lane 0 imem and dmem hit one TIM");
  lane1_tim_conflict: assert property (@(posedge clock) disable iff (!reset)
    !conflict(imem1_in, dmem1_in))
    else $error("tim_router: lane 1 imem and dmem hit one TIM");

endmodule

`default_nettype wire

// File: verilog/tim.sv
`default_nettype none

module tim (
  input  logic                    clock,
  input  logic                    reset,
  input  fabric_pkg::mem_in_type  tim0_in,
  input  fabric_pkg::mem_in_type  tim1_in,
  output fabric_pkg::mem_out_type tim0_out,
  output fabric_pkg::mem_out_type tim1_out
);

  import fabric_pkg::*;

  logic [31:0] mem [tim_words];
  logic [$clog2(tim_words)-1:0] addr0;
  logic [$clog2(tim_words)-1:0] addr1;
  logic ready0;
  logic ready1;
  logic [31:0] rdata0;
  logic [31:0] rdata1;

  assign addr0 = tim0_in.mem_addr[$clog2(tim_words)+1:2];  // word index
  assign addr1 = tim1_in.mem_addr[$clog2(tim_words)+1:2];

  always_ff @(posedge clock) begin
    for (int i = 0; i < 4; i++) begin
      if (tim0_in.mem_valid && tim0_in.mem_wstrb[i]) begin
        mem[addr0][8*i +: 8] <= tim0_in.mem_wdata[8*i +: 8];
      end
      if (tim1_in.mem_valid && tim1_in.mem_wstrb[i]) begin
        mem[addr1][8*i +: 8] <= tim1_in.mem_wdata[8*i +: 8];
      end
    end
    rdata0 <= (tim0_in.mem_valid && tim0_in.mem_wstrb == 4'b0) ? mem[addr0] : 32'h0;
    rdata1 <= (tim1_in.mem_valid && tim1_in.mem_wstrb == 4'b0) ? mem[addr1] : 32'h0;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready0 <= 1'b0;
      ready1 <= 1'b0;
    end else begin
      ready0 <= tim0_in.mem_valid;
      ready1 <= tim1_in.mem_valid;
    end
  end

  assign tim0_out = '{mem_ready: ready0, mem_rdata: rdata0};
  assign tim1_out = '{mem_ready: ready1, mem_rdata: rdata1};

  // the two lanes never store to one word together
  same_word_write: assert property (@(posedge clock) disable iff (!reset)
    !(tim0_in.mem_valid && |tim0_in.mem_wstrb && tim1_in.mem_valid && |tim1_in.mem_wstrb
      && addr0 == addr1))
    else $error("tim: both ports write word %0d", addr0);

endmodule

`default_nettype wire

// File: verilog/fabric_pkg.sv
`default_nettype none

package fabric_pkg;

  // ####################
  // bus types

  typedef struct packed {
    logic        mem_valid;  // one-cycle request strobe
    logic        mem_instr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;  // all zero for a read
  } mem_in_type;

  typedef struct packed {
    logic        mem_ready;  // one-cycle response pulse
    logic [31:0] mem_rdata;
  } mem_out_type;

  localparam mem_in_type  init_mem_in  = '0;
  localparam mem_out_type init_mem_out = '0;

  // ####################
  // address map

  localparam logic [31:0] itim_base_addr  = 32'h0000_0000;
  localparam logic [31:0] itim_mask_addr  = 32'h0000_0FFF;
  localparam logic [31:0] dtim_base_addr  = 32'h0001_0000;
  localparam logic [31:0] dtim_mask_addr  = 32'h0000_0FFF;
  localparam logic [31:0] ram_base_addr   = 32'h8000_0000;
  localparam logic [31:0] ram_mask_addr   = 32'h0000_03FF;
  localparam logic [31:0] clint_base_addr = 32'h0200_0000;
  localparam logic [31:0] clint_mask_addr = 32'h0000_000F;

  localparam int tim_words     = 1024;
  localparam int ram_words     = 256;
  localparam int clint_divider = 4;  // clocks per mtime tick

  localparam logic [31:0] clint_msip_off     = 32'h0;
  localparam logic [31:0] clint_mtimecmp_off = 32'h4;
  localparam logic [31:0] clint_mtime_off    = 32'h8;

  // bits outside the mask must equal the base
  function automatic logic addr_hit(input logic [31:0] addr, input logic [31:0] base,
                                    input logic [31:0] mask);
    return (addr & ~mask) == base;
  endfunction

endpackage

`default_nettype wire
